// ==== cfg_slice.sv ====
// Tile configuration registers for freeze, core id and device ids
`timescale 1ns/1ps
`default_nettype none

module cfg_slice
  import mem_tile_pkg::*;
(
  input  wire logic    clk_i,
  input  wire logic    rst_n_i,
  input  wire logic    cmd_v_i,
  input  wire mem_op_e cmd_op_i,
  input  wire paddr_t  cmd_addr_i,
  input  wire dword_t  cmd_data_i,
  input  wire logic    resp_yumi_i,
  input  wire did_t    my_did_i,
  input  wire did_t    host_did_i,
  output logic         cmd_ready_o,
  output logic         resp_v_o,
  output mem_op_e      resp_op_o,
  output paddr_t       resp_addr_o,
  output dword_t       resp_data_o,
  output logic         freeze_o,
  output did_t         core_id_o
);

  localparam logic [DEV_LSB-1:0] FREEZE_OFF   = 'h0;
  localparam logic [DEV_LSB-1:0] CORE_ID_OFF  = 'h4;
  localparam logic [DEV_LSB-1:0] DID_OFF      = 'h8;
  localparam logic [DEV_LSB-1:0] HOST_DID_OFF = 'hC;

  logic               accept;
  logic [DEV_LSB-1:0] offset;
  logic               freeze_r;
  did_t               core_id_r;
  dword_t             rd_data;

  assign accept = cmd_v_i && cmd_ready_o;
  assign offset = cmd_addr_i[DEV_LSB-1:0];

  always_comb
  begin
    rd_data = '0;
    case (offset)
      FREEZE_OFF:   rd_data = dword_t'(freeze_r);
      CORE_ID_OFF:  rd_data = dword_t'(core_id_r);
      DID_OFF:      rd_data = dword_t'(my_did_i);
      HOST_DID_OFF: rd_data = dword_t'(host_did_i);
      default:      rd_data = '0;
    endcase
  end

  // Core held frozen out of reset until software releases it
  always_ff @(posedge clk_i)
  begin
    if (!rst_n_i)
    begin
      freeze_r  <= 1'b1;
      core_id_r <= '0;
    end
    else if (accept && (cmd_op_i == e_mem_wr))
    begin
      if (offset == FREEZE_OFF)
        freeze_r <= cmd_data_i[0];
      if (offset == CORE_ID_OFF)
        core_id_r <= cmd_data_i[DID_W-1:0];
    end
  end

  always_ff @(posedge clk_i)
  begin
    if (!rst_n_i)
      resp_v_o <= 1'b0;
    else if (accept)
      resp_v_o <= 1'b1;
    else if (resp_yumi_i)
      resp_v_o <= 1'b0;
  end

  always_ff @(posedge clk_i)
  begin
    if (accept)
    begin
      resp_op_o   <= cmd_op_i;
      resp_addr_o <= cmd_addr_i;
      resp_data_o <= (cmd_op_i == e_mem_rd) ? rd_data : '0;
    end
  end

  assign cmd_ready_o = !resp_v_o;
  assign freeze_o    = freeze_r;
  assign core_id_o   = core_id_r;

  a_resp_held: assert property (
    @(posedge clk_i) disable iff (!rst_n_i)
    resp_v_o && !resp_yumi_i |=> resp_v_o
  );

endmodule

`default_nettype wire

// ==== clint_slice.sv ====
// CLINT slice with mtime, mtimecmp and msip driving the timer and software irqs
`timescale 1ns/1ps
`default_nettype none

module clint_slice
  import mem_tile_pkg::*;
(
  input  wire logic    clk_i,
  input  wire logic    rst_n_i,
  input  wire logic    cmd_v_i,
  input  wire mem_op_e cmd_op_i,
  input  wire paddr_t  cmd_addr_i,
  input  wire dword_t  cmd_data_i,
  input  wire logic    resp_yumi_i,
  output logic         cmd_ready_o,
  output logic         resp_v_o,
  output mem_op_e      resp_op_o,
  output paddr_t       resp_addr_o,
  output dword_t       resp_data_o,
  output logic         timer_irq_o,
  output logic         software_irq_o
);

  localparam logic [DEV_LSB-1:0] MSIP_OFF     = 'h0000;
  localparam logic [DEV_LSB-1:0] MTIMECMP_OFF = 'h4000;
  localparam logic [DEV_LSB-1:0] MTIME_OFF    = 'hBFF8;

  logic               accept;
  logic               wr;
  logic [DEV_LSB-1:0] offset;
  logic               mtime_wr;
  logic               msip_r;
  dword_t             mtime_r;
  dword_t             mtimecmp_r;
  logic               timer_irq_r;
  dword_t             rd_data;

  assign accept   = cmd_v_i && cmd_ready_o;
  assign wr       = accept && (cmd_op_i == e_mem_wr);
  assign offset   = cmd_addr_i[DEV_LSB-1:0];
  assign mtime_wr = wr && (offset == MTIME_OFF);

  always_comb
  begin
    rd_data = '0;
    case (offset)
      MSIP_OFF:     rd_data = dword_t'(msip_r);
      MTIMECMP_OFF: rd_data = mtimecmp_r;
      MTIME_OFF:    rd_data = mtime_r;
      default:      rd_data = '0;
    endcase
  end

  // Software write wins over the increment
  always_ff @(posedge clk_i)
  begin
    if (!rst_n_i)
      mtime_r <= '0;
    else if (mtime_wr)
      mtime_r <= cmd_data_i;
    else
      mtime_r <= mtime_r + dword_t'(1);
  end

  always_ff @(posedge clk_i)
  begin
    if (!rst_n_i)
    begin
      msip_r     <= 1'b0;
      mtimecmp_r <= '1;
    end
    else if (wr)
    begin
      if (offset == MSIP_OFF)
        msip_r <= cmd_data_i[0];
      if (offset == MTIMECMP_OFF)
        mtimecmp_r <= cmd_data_i;
    end
  end

  always_ff @(posedge clk_i)
  begin
    if (!rst_n_i)
      timer_irq_r <= 1'b0;
    else
      timer_irq_r <= (mtime_r >= mtimecmp_r);
  end

  always_ff @(posedge clk_i)
  begin
    if (!rst_n_i)
      resp_v_o <= 1'b0;
    else if (accept)
      resp_v_o <= 1'b1;
    else if (resp_yumi_i)
      resp_v_o <= 1'b0;
  end

  always_ff @(posedge clk_i)
  begin
    if (accept)
    begin
      resp_op_o   <= cmd_op_i;
      resp_addr_o <= cmd_addr_i;
      resp_data_o <= (cmd_op_i == e_mem_rd) ? rd_data : '0;
    end
  end

  assign cmd_ready_o    = !resp_v_o;
  assign timer_irq_o    = timer_irq_r;
  assign software_irq_o = msip_r;

  a_mtime_write: assert property (
    @(posedge clk_i) disable iff (!rst_n_i)
    mtime_wr |=> (mtime_r == $past(cmd_data_i))
  );

endmodule

`default_nettype wire

// ==== mem_cmd_demux.sv ====
// Command demux that decodes the address and steers valid to one target
`timescale 1ns/1ps
`default_nettype none

module mem_cmd_demux
  import mem_tile_pkg::*;
#(
  parameter paddr_t DRAM_BASE_ADDR = DRAM_BASE_DEFAULT
)
(
  input  wire logic   clk_i,
  input  wire logic   rst_n_i,
  input  wire logic   cmd_v_i,
  input  wire paddr_t cmd_addr_i,
  input  wire logic   cfg_ready_i,
  input  wire logic   clint_ready_i,
  input  wire logic   loop_ready_i,
  input  wire logic   dram_ready_i,
  output logic        cmd_ready_o,
  output logic        cfg_v_o,
  output logic        clint_v_o,
  output logic        loop_v_o,
  output logic        dram_v_o
);

  logic    is_local;
  dev_id_t dev_sel;
  logic    is_cfg;
  logic    is_clint;
  logic    is_dram;
  logic    is_loop;

  assign is_local = (cmd_addr_i < DRAM_BASE_ADDR);
  assign dev_sel  = cmd_addr_i[DEV_LSB +: DEV_W];

  assign is_cfg   = is_local && (dev_sel == CFG_DEV);
  assign is_clint = is_local && (dev_sel == CLINT_DEV);
  // Cacheable local space has no L2 here, so it shares the DRAM path
  assign is_dram  = !is_local || (dev_sel == CACHE_DEV);
  assign is_loop  = is_local && !is_cfg && !is_clint && !is_dram;

  assign cmd_ready_o = cfg_ready_i & clint_ready_i & loop_ready_i & dram_ready_i;

  // Each valid waits on the other targets, never on its own ready
  assign cfg_v_o   = cmd_v_i & is_cfg & clint_ready_i & loop_ready_i & dram_ready_i;
  assign clint_v_o = cmd_v_i & is_clint & cfg_ready_i & loop_ready_i & dram_ready_i;
  assign loop_v_o  = cmd_v_i & is_loop & cfg_ready_i & clint_ready_i & dram_ready_i;
  assign dram_v_o  = cmd_v_i & is_dram & cfg_ready_i & clint_ready_i & loop_ready_i;

  a_one_target: assert property (
    @(posedge clk_i) disable iff (!rst_n_i)
    $onehot0({cfg_v_o, clint_v_o, loop_v_o, dram_v_o})
  );

endmodule

`default_nettype wire

// ==== mem_loopback.sv ====
// Loopback target that answers unmapped local commands with zero data
`timescale 1ns/1ps
`default_nettype none

module mem_loopback
  import mem_tile_pkg::*;
(
  input  wire logic    clk_i,
  input  wire logic    rst_n_i,
  input  wire logic    cmd_v_i,
  input  wire mem_op_e cmd_op_i,
  input  wire paddr_t  cmd_addr_i,
  input  wire logic    resp_yumi_i,
  output logic         cmd_ready_o,
  output logic         resp_v_o,
  output mem_op_e      resp_op_o,
  output paddr_t       resp_addr_o,
  output dword_t       resp_data_o
);

  logic accept;

  assign accept = cmd_v_i && cmd_ready_o;

  always_ff @(posedge clk_i)
  begin
    if (!rst_n_i)
      resp_v_o <= 1'b0;
    else if (accept)
      resp_v_o <= 1'b1;
    else if (resp_yumi_i)
      resp_v_o <= 1'b0;
  end

  // Echo header only
  always_ff @(posedge clk_i)
  begin
    if (accept)
    begin
      resp_op_o   <= cmd_op_i;
      resp_addr_o <= cmd_addr_i;
    end
  end

  assign cmd_ready_o = !resp_v_o;
  assign resp_data_o = '0;

endmodule

`default_nettype wire

// ==== mem_resp_arbiter.sv ====
// Fixed-priority response arbiter feeding a two-entry response FIFO
`timescale 1ns/1ps
`default_nettype none

module mem_resp_arbiter
  import mem_tile_pkg::*;
(
  input  wire logic    clk_i,
  input  wire logic    rst_n_i,
  input  wire logic    dram_v_i,
  input  wire mem_op_e dram_op_i,
  input  wire paddr_t  dram_addr_i,
  input  wire dword_t  dram_data_i,
  input  wire logic    cfg_v_i,
  input  wire mem_op_e cfg_op_i,
  input  wire paddr_t  cfg_addr_i,
  input  wire dword_t  cfg_data_i,
  input  wire logic    clint_v_i,
  input  wire mem_op_e clint_op_i,
  input  wire paddr_t  clint_addr_i,
  input  wire dword_t  clint_data_i,
  input  wire logic    loop_v_i,
  input  wire mem_op_e loop_op_i,
  input  wire paddr_t  loop_addr_i,
  input  wire dword_t  loop_data_i,
  input  wire logic    resp_yumi_i,
  output logic         dram_yumi_o,
  output logic         cfg_yumi_o,
  output logic         clint_yumi_o,
  output logic         loop_yumi_o,
  output logic         resp_v_o,
  output mem_op_e      resp_op_o,
  output paddr_t       resp_addr_o,
  output dword_t       resp_data_o
);

  mem_op_e    op_mem   [2];
  paddr_t     addr_mem [2];
  dword_t     data_mem [2];
  logic       wr_ptr;
  logic       rd_ptr;
  logic [1:0] count;
  logic       full;
  logic       push;
  logic       pop;
  mem_op_e    sel_op;
  paddr_t     sel_addr;
  dword_t     sel_data;

  assign full = (count == 2'd2);

  // DRAM first, loopback last
  assign dram_yumi_o  = !full && dram_v_i;
  assign cfg_yumi_o   = !full && !dram_v_i && cfg_v_i;
  assign clint_yumi_o = !full && !dram_v_i && !cfg_v_i && clint_v_i;
  assign loop_yumi_o  = !full && !dram_v_i && !cfg_v_i && !clint_v_i && loop_v_i;

  assign push = dram_yumi_o | cfg_yumi_o | clint_yumi_o | loop_yumi_o;
  assign pop  = resp_v_o && resp_yumi_i;

  always_comb
  begin
    if (dram_v_i)
      {sel_op, sel_addr, sel_data} = {dram_op_i, dram_addr_i, dram_data_i};
    else if (cfg_v_i)
      {sel_op, sel_addr, sel_data} = {cfg_op_i, cfg_addr_i, cfg_data_i};
    else if (clint_v_i)
      {sel_op, sel_addr, sel_data} = {clint_op_i, clint_addr_i, clint_data_i};
    else
      {sel_op, sel_addr, sel_data} = {loop_op_i, loop_addr_i, loop_data_i};
  end

  always_ff @(posedge clk_i)
  begin
    if (push)
    begin
      op_mem[wr_ptr]   <= sel_op;
      addr_mem[wr_ptr] <= sel_addr;
      data_mem[wr_ptr] <= sel_data;
    end
  end

  always_ff @(posedge clk_i)
  begin
    if (!rst_n_i)
    begin
      wr_ptr <= 1'b0;
      rd_ptr <= 1'b0;
      count  <= 2'd0;
    end
    else
    begin
      if (push)
        wr_ptr <= !wr_ptr;
      if (pop)
        rd_ptr <= !rd_ptr;
      count <= count + 2'(push) - 2'(pop);
    end
  end

  assign resp_v_o    = (count != 2'd0);
  assign resp_op_o   = op_mem[rd_ptr];
  assign resp_addr_o = addr_mem[rd_ptr];
  assign resp_data_o = data_mem[rd_ptr];

  a_grant_onehot: assert property (
    @(posedge clk_i) disable iff (!rst_n_i)
    $onehot0({dram_yumi_o, cfg_yumi_o, clint_yumi_o, loop_yumi_o})
  );

  a_no_overflow: assert property (
    @(posedge clk_i) disable iff (!rst_n_i)
    push |-> (count < 2'd2)
  );

endmodule

`default_nettype wire

// ==== mem_tile.f ====
mem_tile_pkg.sv
mem_cmd_demux.sv
cfg_slice.sv
clint_slice.sv
mem_loopback.sv
mem_resp_arbiter.sv
mem_tile.sv
mem_tile_tb.sv

// ==== mem_tile.sv ====
// Memory-side tile network routing commands to cfg, CLINT, loopback and DRAM
`timescale 1ns/1ps
`default_nettype none

module mem_tile
  import mem_tile_pkg::*;
#(
  parameter paddr_t DRAM_BASE_ADDR = DRAM_BASE_DEFAULT
)
(
  input  wire logic    clk_i,
  input  wire logic    rst_n_i,
  input  wire logic    cmd_v_i,
  input  wire mem_op_e cmd_op_i,
  input  wire paddr_t  cmd_addr_i,
  input  wire dword_t  cmd_data_i,
  output logic         cmd_ready_o,
  output logic         resp_v_o,
  output mem_op_e      resp_op_o,
  output paddr_t       resp_addr_o,
  output dword_t       resp_data_o,
  input  wire logic    resp_yumi_i,
  output logic         dram_cmd_v_o,
  output mem_op_e      dram_cmd_op_o,
  output paddr_t       dram_cmd_addr_o,
  output dword_t       dram_cmd_data_o,
  input  wire logic    dram_cmd_ready_i,
  input  wire logic    dram_resp_v_i,
  input  wire mem_op_e dram_resp_op_i,
  input  wire paddr_t  dram_resp_addr_i,
  input  wire dword_t  dram_resp_data_i,
  output logic         dram_resp_yumi_o,
  input  wire did_t    my_did_i,
  input  wire did_t    host_did_i,
  output logic         freeze_o,
  output did_t         core_id_o,
  output logic         timer_irq_o,
  output logic         software_irq_o
);

  logic    cfg_v, cfg_ready, cfg_resp_v, cfg_yumi;
  logic    clint_v, clint_ready, clint_resp_v, clint_yumi;
  logic    loop_v, loop_ready, loop_resp_v, loop_yumi;
  mem_op_e cfg_resp_op, clint_resp_op, loop_resp_op;
  paddr_t  cfg_resp_addr, clint_resp_addr, loop_resp_addr;
  dword_t  cfg_resp_data, clint_resp_data, loop_resp_data;

  // Header and data fan out to every target unchanged
  assign dram_cmd_op_o   = cmd_op_i;
  assign dram_cmd_addr_o = cmd_addr_i;
  assign dram_cmd_data_o = cmd_data_i;

  mem_cmd_demux #(.DRAM_BASE_ADDR(DRAM_BASE_ADDR)) u_demux (
    .clk_i(clk_i), .rst_n_i(rst_n_i), .cmd_v_i(cmd_v_i), .cmd_addr_i(cmd_addr_i),
    .cfg_ready_i(cfg_ready), .clint_ready_i(clint_ready), .loop_ready_i(loop_ready),
    .dram_ready_i(dram_cmd_ready_i), .cmd_ready_o(cmd_ready_o), .cfg_v_o(cfg_v),
    .clint_v_o(clint_v), .loop_v_o(loop_v), .dram_v_o(dram_cmd_v_o)
  );

  cfg_slice u_cfg (
    .clk_i(clk_i), .rst_n_i(rst_n_i), .cmd_v_i(cfg_v), .cmd_op_i(cmd_op_i),
    .cmd_addr_i(cmd_addr_i), .cmd_data_i(cmd_data_i), .resp_yumi_i(cfg_yumi),
    .my_did_i(my_did_i), .host_did_i(host_did_i), .cmd_ready_o(cfg_ready),
    .resp_v_o(cfg_resp_v), .resp_op_o(cfg_resp_op), .resp_addr_o(cfg_resp_addr),
    .resp_data_o(cfg_resp_data), .freeze_o(freeze_o), .core_id_o(core_id_o)
  );

  clint_slice u_clint (
    .clk_i(clk_i), .rst_n_i(rst_n_i), .cmd_v_i(clint_v), .cmd_op_i(cmd_op_i),
    .cmd_addr_i(cmd_addr_i), .cmd_data_i(cmd_data_i), .resp_yumi_i(clint_yumi),
    .cmd_ready_o(clint_ready), .resp_v_o(clint_resp_v), .resp_op_o(clint_resp_op),
    .resp_addr_o(clint_resp_addr), .resp_data_o(clint_resp_data),
    .timer_irq_o(timer_irq_o), .software_irq_o(software_irq_o)
  );

  mem_loopback u_loop (
    .clk_i(clk_i), .rst_n_i(rst_n_i), .cmd_v_i(loop_v), .cmd_op_i(cmd_op_i),
    .cmd_addr_i(cmd_addr_i), .resp_yumi_i(loop_yumi), .cmd_ready_o(loop_ready),
    .resp_v_o(loop_resp_v), .resp_op_o(loop_resp_op), .resp_addr_o(loop_resp_addr),
    .resp_data_o(loop_resp_data)
  );

  mem_resp_arbiter u_arb (
    .clk_i(clk_i), .rst_n_i(rst_n_i),
    .dram_v_i(dram_resp_v_i), .dram_op_i(dram_resp_op_i),
    .dram_addr_i(dram_resp_addr_i), .dram_data_i(dram_resp_data_i),
    .cfg_v_i(cfg_resp_v), .cfg_op_i(cfg_resp_op),
    .cfg_addr_i(cfg_resp_addr), .cfg_data_i(cfg_resp_data),
    .clint_v_i(clint_resp_v), .clint_op_i(clint_resp_op),
    .clint_addr_i(clint_resp_addr), .clint_data_i(clint_resp_data),
    .loop_v_i(loop_resp_v), .loop_op_i(loop_resp_op),
    .loop_addr_i(loop_resp_addr), .loop_data_i(loop_resp_data),
    .resp_yumi_i(resp_yumi_i), .dram_yumi_o(dram_resp_yumi_o), .cfg_yumi_o(cfg_yumi),
    .clint_yumi_o(clint_yumi), .loop_yumi_o(loop_yumi), .resp_v_o(resp_v_o),
    .resp_op_o(resp_op_o), .resp_addr_o(resp_addr_o), .resp_data_o(resp_data_o)
  );

endmodule

`default_nettype wire

// ==== mem_tile_pkg.sv ====
// Memory tile package with widths, typedefs, opcodes and the local memory map
`default_nettype none

package mem_tile_pkg;

  // Bus widths
  localparam int PADDR_W = 40;
  localparam int DWORD_W = 64;
  localparam int DID_W   = 16;

  // Device-select field in the physical address
  localparam int DEV_W   = 4;
  localparam int DEV_LSB = 20;

  typedef logic [PADDR_W-1:0] paddr_t;
  typedef logic [DWORD_W-1:0] dword_t;
  typedef logic [DID_W-1:0]   did_t;
  typedef logic [DEV_W-1:0]   dev_id_t;

  typedef enum logic [0:0]
  {
    e_mem_rd = 1'b0,
    e_mem_wr = 1'b1
  } mem_op_e;

  // Local device numbers
  localparam dev_id_t CLINT_DEV = 4'd1;
  localparam dev_id_t CFG_DEV   = 4'd2;
  localparam dev_id_t CACHE_DEV = 4'd3;

  // Everything at or above this goes off-tile
  localparam paddr_t DRAM_BASE_DEFAULT = 40'h00_8000_0000;

endpackage

`default_nettype wire

// ==== mem_tile_tb.sv ====
// Memory tile testbench with a DRAM responder model and a response scoreboard
`timescale 1ns/1ps
`default_nettype none

module mem_tile_tb
  import mem_tile_pkg::*;
();

  localparam int     NUM_TESTS      = 6;
  localparam int     TIMEOUT_CYCLES = NUM_TESTS * 200 + 100;
  localparam dword_t DRAM_XOR       = 64'h5a5a_0f0f_c3c3_9696;
  localparam did_t   MY_DID         = 16'h0123;
  localparam did_t   HOST_DID       = 16'h0f00;

  localparam paddr_t FREEZE_ADDR   = 40'h00_0020_0000;
  localparam paddr_t CORE_ID_ADDR  = 40'h00_0020_0004;
  localparam paddr_t DID_ADDR      = 40'h00_0020_0008;
  localparam paddr_t HOST_DID_ADDR = 40'h00_0020_000C;
  localparam paddr_t MSIP_ADDR     = 40'h00_0010_0000;
  localparam paddr_t MTIMECMP_ADDR = 40'h00_0010_4000;
  localparam paddr_t MTIME_ADDR    = 40'h00_0010_BFF8;

  logic    clk;
  logic    rst_n;
  logic    cmd_v;
  mem_op_e cmd_op;
  paddr_t  cmd_addr;
  dword_t  cmd_data;
  logic    cmd_ready;
  logic    resp_v;
  mem_op_e resp_op;
  paddr_t  resp_addr;
  dword_t  resp_data;
  logic    resp_yumi;
  logic    dram_cmd_v;
  mem_op_e dram_cmd_op;
  paddr_t  dram_cmd_addr;
  dword_t  dram_cmd_data;
  logic    dram_cmd_ready;
  logic    dram_resp_v;
  mem_op_e dram_resp_op;
  paddr_t  dram_resp_addr;
  dword_t  dram_resp_data;
  logic    dram_resp_yumi;
  did_t    my_did;
  did_t    host_did;
  logic    freeze;
  did_t    core_id;
  logic    timer_irq;
  logic    software_irq;

  // Expected responses, matched by address
  paddr_t  sb_addr  [$];
  mem_op_e sb_op    [$];
  dword_t  sb_data  [$];
  logic    sb_known [$];

  int     errors = 0;
  int     checks = 0;
  int     tests_run = 0;
  int     errs_at_start = 0;
  string  test_name = "reset";
  dword_t last_data;
  logic   yumi_en;
  logic   saw_ready_low;

  mem_tile #(.DRAM_BASE_ADDR(DRAM_BASE_DEFAULT)) DUT (
    .clk_i(clk), .rst_n_i(rst_n), .cmd_v_i(cmd_v), .cmd_op_i(cmd_op),
    .cmd_addr_i(cmd_addr), .cmd_data_i(cmd_data), .cmd_ready_o(cmd_ready),
    .resp_v_o(resp_v), .resp_op_o(resp_op), .resp_addr_o(resp_addr),
    .resp_data_o(resp_data), .resp_yumi_i(resp_yumi),
    .dram_cmd_v_o(dram_cmd_v), .dram_cmd_op_o(dram_cmd_op),
    .dram_cmd_addr_o(dram_cmd_addr), .dram_cmd_data_o(dram_cmd_data),
    .dram_cmd_ready_i(dram_cmd_ready), .dram_resp_v_i(dram_resp_v),
    .dram_resp_op_i(dram_resp_op), .dram_resp_addr_i(dram_resp_addr),
    .dram_resp_data_i(dram_resp_data), .dram_resp_yumi_o(dram_resp_yumi),
    .my_did_i(my_did), .host_did_i(host_did), .freeze_o(freeze), .core_id_o(core_id),
    .timer_irq_o(timer_irq), .software_irq_o(software_irq)
  );

  initial
  begin
    clk = 1'b0;
    forever
      #50 clk = ~clk;
  end

  task automatic check_val(input string what, input dword_t exp, input dword_t act);
    checks++;
    assert (exp === act)
    else
    begin
      errors++;
      $display("CHECK FAILED %s: %s expected 0x%h actual 0x%h", test_name, what, exp, act);
    end
  endtask

  task automatic send_cmd(input mem_op_e op, input paddr_t addr, input dword_t data,
                          input dword_t exp, input logic known);
    sb_op.push_back(op);
    sb_addr.push_back(addr);
    sb_data.push_back(exp);
    sb_known.push_back(known);
    @(negedge clk);
    cmd_v    = 1'b1;
    cmd_op   = op;
    cmd_addr = addr;
    cmd_data = data;
    @(posedge clk);
    while (!cmd_ready)
      @(posedge clk);
    @(negedge clk);
    cmd_v = 1'b0;
  endtask

  task automatic wait_drained();
    while (sb_addr.size() != 0)
      @(negedge clk);
  endtask

  task automatic access(input mem_op_e op, input paddr_t addr, input dword_t data,
                        input dword_t exp, input logic known);
    send_cmd(op, addr, data, exp, known);
    wait_drained();
  endtask

  task automatic start_test(input string name);
    test_name     = name;
    errs_at_start = errors;
  endtask

  task automatic finish_test();
    tests_run++;
    if (errors == errs_at_start)
      $display("Test %0d %s: ok", tests_run, test_name);
    else
      $display("Test %0d %s: %0d failed checks", tests_run, test_name, errors - errs_at_start);
  endtask

  // Yumi only while a response is offered
  initial
  begin
    resp_yumi = 1'b0;
    forever
    begin
      @(negedge clk);
      resp_yumi = yumi_en && resp_v;
    end
  end

  initial
  begin : resp_monitor
    int idx;
    forever
    begin
      @(posedge clk);
      if (rst_n && resp_v && resp_yumi)
      begin
        idx = -1;
        foreach (sb_addr[i])
          if (idx < 0 && sb_addr[i] == resp_addr)
            idx = i;
        assert (idx >= 0)
        else
        begin
          errors++;
          $display("Response for address 0x%h was not expected in %s", resp_addr, test_name);
        end
        if (idx >= 0)
        begin
          check_val("response op", dword_t'(sb_op[idx]), dword_t'(resp_op));
          if (sb_known[idx])
            check_val("response data", sb_data[idx], resp_data);
          last_data = resp_data;
          sb_addr.delete(idx);
          sb_op.delete(idx);
          sb_data.delete(idx);
          sb_known.delete(idx);
        end
      end
    end
  end

  // DRAM model, one command at a time, answers after 1 to 4 cycles
  initial
  begin : dram_model
    mem_op_e     op_q;
    paddr_t      addr_q;
    int unsigned lat;
    dram_cmd_ready = 1'b0;
    dram_resp_v    = 1'b0;
    dram_resp_op   = e_mem_rd;
    dram_resp_addr = '0;
    dram_resp_data = '0;
    wait (rst_n === 1'b1);
    @(negedge clk);
    forever
    begin
      dram_cmd_ready = 1'b1;
      @(posedge clk);
      while (!dram_cmd_v)
        @(posedge clk);
      op_q   = dram_cmd_op;
      addr_q = dram_cmd_addr;
      check_val("dram cmd op", dword_t'(cmd_op), dword_t'(dram_cmd_op));
      check_val("dram cmd addr", dword_t'(cmd_addr), dword_t'(dram_cmd_addr));
      check_val("dram cmd data", cmd_data, dram_cmd_data);
      lat = $urandom_range(4, 1);
      @(negedge clk);
      dram_cmd_ready = 1'b0;
      repeat (lat - 1)
        @(negedge clk);
      dram_resp_v    = 1'b1;
      dram_resp_op   = op_q;
      dram_resp_addr = addr_q;
      dram_resp_data = (op_q == e_mem_rd) ? (dword_t'(addr_q) ^ DRAM_XOR) : 64'd0;
      @(posedge clk);
      while (!dram_resp_yumi)
        @(posedge clk);
      @(negedge clk);
      dram_resp_v = 1'b0;
    end
  end

  a_dram_yumi_valid: assert property (
    @(posedge clk) disable iff (!rst_n)
    dram_resp_yumi |-> dram_resp_v
  )
  else
  begin
    errors++;
    $display("DRAM response taken while none was offered in %s", test_name);
  end

  a_resp_hold: assert property (
    @(posedge clk) disable iff (!rst_n)
    resp_v && !resp_yumi |=> resp_v && $stable(resp_addr)
  )
  else
  begin
    errors++;
    $display("Response withdrawn or changed before yumi in %s", test_name);
  end

  initial
  begin
    repeat (TIMEOUT_CYCLES)
      @(posedge clk);
    $display("Timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
    $display("ERRORS FOUND");
    $finish;
  end

  initial
  begin : main
    dword_t      t0;
    int unsigned stall;
    cmd_v         = 1'b0;
    cmd_op        = e_mem_rd;
    cmd_addr      = '0;
    cmd_data      = '0;
    rst_n         = 1'b0;
    yumi_en       = 1'b1;
    saw_ready_low = 1'b0;
    my_did        = MY_DID;
    host_did      = HOST_DID;
    void'($urandom(32'hd454_8669));
    repeat (5)
      @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;

    start_test("cfg_regs");
    check_val("freeze after reset", 64'd1, dword_t'(freeze));
    check_val("irqs after reset", 64'd0, dword_t'({timer_irq, software_irq}));
    check_val("valids after reset", 64'd0, dword_t'({resp_v, dram_cmd_v}));
    access(e_mem_wr, FREEZE_ADDR, 64'd0, 64'd0, 1'b1);
    check_val("freeze released", 64'd0, dword_t'(freeze));
    access(e_mem_wr, CORE_ID_ADDR, 64'h5a3c, 64'd0, 1'b1);
    access(e_mem_rd, CORE_ID_ADDR, 64'd0, 64'h5a3c, 1'b1);
    check_val("core_id output", 64'h5a3c, dword_t'(core_id));
    access(e_mem_rd, DID_ADDR, 64'd0, dword_t'(MY_DID), 1'b1);
    access(e_mem_rd, HOST_DID_ADDR, 64'd0, dword_t'(HOST_DID), 1'b1);
    finish_test();

    start_test("msip");
    access(e_mem_wr, MSIP_ADDR, 64'd1, 64'd0, 1'b1);
    check_val("software irq set", 64'd1, dword_t'(software_irq));
    access(e_mem_wr, MSIP_ADDR, 64'd0, 64'd0, 1'b1);
    check_val("software irq clear", 64'd0, dword_t'(software_irq));
    finish_test();

    start_test("mtime");
    access(e_mem_rd, MTIME_ADDR, 64'd0, 64'd0, 1'b0);
    t0 = last_data;
    access(e_mem_rd, MTIME_ADDR, 64'd0, 64'd0, 1'b0);
    check_val("mtime increases", 64'd1, dword_t'(last_data > t0));
    access(e_mem_wr, MTIMECMP_ADDR, 64'd0, 64'd0, 1'b1);
    @(negedge clk);
    check_val("timer irq raised", 64'd1, dword_t'(timer_irq));
    access(e_mem_wr, MTIMECMP_ADDR, '1, 64'd0, 1'b1);
    @(negedge clk);
    check_val("timer irq dropped", 64'd0, dword_t'(timer_irq));
    finish_test();

    start_test("dram");
    access(e_mem_rd, 40'h00_8000_1230, 64'd0, 64'h00_8000_1230 ^ DRAM_XOR, 1'b1);
    access(e_mem_wr, 40'h00_9000_0040, 64'hdead_beef_0123_4567, 64'd0, 1'b1);
    access(e_mem_rd, 40'h00_0030_0100, 64'd0, 64'h00_0030_0100 ^ DRAM_XOR, 1'b1);
    finish_test();

    start_test("loopback");
    access(e_mem_rd, 40'h00_0050_0010, 64'd0, 64'd0, 1'b1);
    access(e_mem_wr, 40'h00_00F0_0020, 64'h1234, 64'd0, 1'b1);
    access(e_mem_rd, 40'h00_0000_0008, 64'd0, 64'd0, 1'b1);
    finish_test();

    start_test("backpressure");
    yumi_en = 1'b0;
    stall   = $urandom_range(40, 20);
    fork
      begin
        send_cmd(e_mem_rd, DID_ADDR, 64'd0, dword_t'(MY_DID), 1'b1);
        send_cmd(e_mem_rd, MSIP_ADDR, 64'd0, 64'd0, 1'b1);
        send_cmd(e_mem_rd, 40'h00_0050_0100, 64'd0, 64'd0, 1'b1);
        send_cmd(e_mem_rd, 40'h00_8000_2000, 64'd0, 64'h00_8000_2000 ^ DRAM_XOR, 1'b1);
        send_cmd(e_mem_rd, 40'h00_0030_0200, 64'd0, 64'h00_0030_0200 ^ DRAM_XOR, 1'b1);
        send_cmd(e_mem_wr, 40'h00_0060_0300, 64'h77, 64'd0, 1'b1);
        send_cmd(e_mem_rd, HOST_DID_ADDR, 64'd0, dword_t'(HOST_DID), 1'b1);
        send_cmd(e_mem_rd, MTIMECMP_ADDR, 64'd0, '1, 1'b1);
      end
      begin
        repeat (stall)
          @(posedge clk);
        // FIFO full and a target pending by now
        saw_ready_low = !cmd_ready;
        yumi_en = 1'b1;
      end
    join
    wait_drained();
    // Any duplicate response would show up here as unexpected
    repeat (5)
      @(negedge clk);
    check_val("cmd_ready held low under stall", 64'd1, dword_t'(saw_ready_low));
    finish_test();

    $display("Tests run: %0d, checks: %0d, failed checks: %0d", tests_run, checks, errors);
    if (errors == 0)
      $display("NO ERRORS");
    else
      $display("ERRORS FOUND");
    $finish;
  end

endmodule

`default_nettype wire

// ==== run.sh ====
#!/usr/bin/env bash
set -o pipefail
cd "$(dirname "$0")" || exit 1

verilator --binary --assert --timescale 1ns/1ps --top-module mem_tile_tb \
  -f mem_tile.f -o mem_tile_sim \
  && ./obj_dir/mem_tile_sim 2>&1 | tee sim.log \
  || { echo "Build or simulation did not complete"; exit 1; }

grep -q "ERRORS FOUND" sim.log && { echo "Simulation failed"; exit 1; } \
  || echo "Simulation passed"
